/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bell_game
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_FLAGS ?= +verilator+error+limit+100

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) bell_game_macros.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)

/* bell_game_macros.svh */
`ifndef BELL_GAME_MACROS_SVH
`define BELL_GAME_MACROS_SVH

// keypad codes for the two bells
`define BELL_KEY_A 4'd7
`define BELL_KEY_B 4'd9

// target sum for same colour, target single number otherwise
`define BELL_SUM 5

// score, count and delta width
`define SCORE_W 8

// leader must be ahead by more than this
`define LEAD_MARGIN 50

// card fields
`define COLOR_W 2
`define NUM_W 3

`endif

/* bell_game_pkg.sv */
`default_nettype none

package bell_game_pkg;

    // arbiter states
    typedef enum logic [1:0] {
        IDLE    = 2'b00, // waiting for a press
        HOLD    = 2'b01, // press being scored
        RELEASE = 2'b10  // waiting for keys up
    } buzz_state_e;

    typedef enum logic [1:0] {
        NOBODY   = 2'b00,
        PLAYER_A = 2'b01,
        PLAYER_B = 2'b10
    } player_e;

    // codes match the display signal
    typedef enum logic [1:0] {
        LEAD_NONE = 2'b00,
        LEAD_A    = 2'b01,
        LEAD_B    = 2'b10
    } lead_e;

endpackage

`default_nettype wire

/* bell_game_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bell_game_macros.svh"

module bell_game_props (
    input logic                clk,
    input logic                rst,
    input logic [3:0]          keypad_in,
    input logic [`COLOR_W-1:0] color_a,
    input logic [`COLOR_W-1:0] color_b,
    input logic [`NUM_W-1:0]   num_a,
    input logic [`NUM_W-1:0]   num_b,
    input logic [`SCORE_W-1:0] count,
    input logic [`SCORE_W-1:0] total_a,
    input logic [`SCORE_W-1:0] total_b,
    input logic                round_done,
    input logic [1:0]          lcd_sig,
    input logic                press
);

    int unsigned fail_count = 0; // read by the testbench

    logic [3:0]          key_q;
    logic [`SCORE_W-1:0] exp_da;
    logic [`SCORE_W-1:0] exp_db;
    logic [1:0]          exp_lead;
    logic                keys_up_seen; // keypad left the bell codes since the last round

    function automatic logic ring_matches(input logic [`COLOR_W-1:0] ca,
                                          input logic [`COLOR_W-1:0] cb,
                                          input logic [`NUM_W-1:0]   na,
                                          input logic [`NUM_W-1:0]   nb);
        if (ca == cb) begin
            return (int'(na) + int'(nb)) == `BELL_SUM;
        end
        return (int'(na) == `BELL_SUM) || (int'(nb) == `BELL_SUM);
    endfunction

    function automatic logic [1:0] leader_of(input logic [`SCORE_W-1:0] a,
                                             input logic [`SCORE_W-1:0] b);
        int wa;
        int wb;
        wa = int'(a);
        wb = int'(b);
        if (wa > wb + `LEAD_MARGIN) begin
            return bell_game_pkg::LEAD_A;
        end
        if (wb > wa + `LEAD_MARGIN) begin
            return bell_game_pkg::LEAD_B;
        end
        return bell_game_pkg::LEAD_NONE;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            key_q        <= 4'h0;
            exp_da       <= '0;
            exp_db       <= '0;
            exp_lead     <= bell_game_pkg::LEAD_NONE;
            keys_up_seen <= 1'b1;
        end else begin
            key_q    <= keypad_in;
            exp_lead <= leader_of(total_a, total_b);
            if (press) begin
                // key_q holds the code that raised this press
                if (ring_matches(color_a, color_b, num_a, num_b)) begin
                    exp_da <= (key_q == `BELL_KEY_A) ? count : '0;
                    exp_db <= (key_q == `BELL_KEY_A) ? '0 : count;
                end else begin
                    exp_da <= (key_q == `BELL_KEY_A) ? 8'hff : 8'h01;
                    exp_db <= (key_q == `BELL_KEY_A) ? 8'h01 : 8'hff;
                end
            end
            if (round_done) begin
                keys_up_seen <= 1'b0;
            end else if (keypad_in != `BELL_KEY_A && keypad_in != `BELL_KEY_B) begin
                keys_up_seen <= 1'b1;
            end
        end
    end

    a_reset_clears: assert property (@(posedge clk)
        !rst |=> (!round_done && total_a == '0 && total_b == '0 && lcd_sig == 2'b00))
        else begin
            fail_count++;
            $error("outputs not cleared by reset");
        end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst)
        round_done |=> !round_done)
        else begin
            fail_count++;
            $error("round_done high for two cycles");
        end

    a_score_update: assert property (@(posedge clk) disable iff (!rst)
        round_done |=> (total_a == $past(total_a) + exp_da) &&
                       (total_b == $past(total_b) + exp_db))
        else begin
            fail_count++;
            $error("totals do not follow the ring rule");
        end

    a_totals_hold: assert property (@(posedge clk) disable iff (!rst)
        !round_done |=> $stable(total_a) && $stable(total_b))
        else begin
            fail_count++;
            $error("totals changed without a round_done");
        end

    a_lockout: assert property (@(posedge clk) disable iff (!rst)
        round_done |-> keys_up_seen)
        else begin
            fail_count++;
            $error("second round scored before the keys went up");
        end

    a_lead_code: assert property (@(posedge clk) disable iff (!rst)
        lcd_sig == exp_lead)
        else begin
            fail_count++;
            $error("lcd_sig does not match the lead of the previous totals");
        end

endmodule

bind bell_game_top bell_game_props u_bell_game_props (
    .clk        (clk),
    .rst        (rst),
    .keypad_in  (keypad_in),
    .color_a    (color_a),
    .color_b    (color_b),
    .num_a      (num_a),
    .num_b      (num_b),
    .count      (count),
    .total_a    (total_a),
    .total_b    (total_b),
    .round_done (round_done),
    .lcd_sig    (lcd_sig),
    .press      (press)
);

`default_nettype wire

/* bell_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bell_game_macros.svh"

module bell_game_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [3:0]          keypad_in,
    input  logic [`COLOR_W-1:0] color_a,
    input  logic [`COLOR_W-1:0] color_b,
    input  logic [`NUM_W-1:0]   num_a,
    input  logic [`NUM_W-1:0]   num_b,
    input  logic [`SCORE_W-1:0] count,
    output logic [`SCORE_W-1:0] total_a,
    output logic [`SCORE_W-1:0] total_b,
    output logic                round_done,
    output logic [1:0]          lcd_sig
);

    card_pair_if cards ();

    logic                   press;
    bell_game_pkg::player_e presser;
    logic [`SCORE_W-1:0]    delta_a;
    logic [`SCORE_W-1:0]    delta_b;

    // card ports onto the source side of the bundle
    assign cards.color_a = color_a;
    assign cards.color_b = color_b;
    assign cards.num_a   = num_a;
    assign cards.num_b   = num_b;

    buzz_arbiter u_buzz_arbiter (
        .clk        (clk),
        .rst        (rst),
        .keypad_in  (keypad_in),
        .round_done (round_done),
        .press      (press),
        .presser    (presser)
    );

    round_referee u_round_referee (
        .clk        (clk),
        .rst        (rst),
        .cards      (cards.judge),
        .count      (count),
        .press      (press),
        .presser    (presser),
        .delta_a    (delta_a),
        .delta_b    (delta_b),
        .round_done (round_done)
    );

    score_bank u_score_bank (
        .clk        (clk),
        .rst        (rst),
        .delta_a    (delta_a),
        .delta_b    (delta_b),
        .round_done (round_done),
        .total_a    (total_a),
        .total_b    (total_b)
    );

    lead_monitor u_lead_monitor (
        .clk     (clk),
        .rst     (rst),
        .total_a (total_a),
        .total_b (total_b),
        .lead    (lcd_sig) // lead_e codes drive the display directly
    );

endmodule

`default_nettype wire

/* buzz_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bell_game_macros.svh"

module buzz_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [3:0]             keypad_in,
    input  logic                   round_done,
    output logic                   press,
    output bell_game_pkg::player_e presser
);

    bell_game_pkg::buzz_state_e state;

    logic key_a;
    logic key_b;

    assign key_a = (keypad_in == `BELL_KEY_A);
    assign key_b = (keypad_in == `BELL_KEY_B);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= bell_game_pkg::IDLE;
            press   <= 1'b0;
            presser <= bell_game_pkg::NOBODY;
        end else begin
            press <= 1'b0; // single-cycle pulse by default
            case (state)
                bell_game_pkg::IDLE: begin
                    if (key_a) begin // A wins a tie
                        press   <= 1'b1;
                        presser <= bell_game_pkg::PLAYER_A;
                        state   <= bell_game_pkg::HOLD;
                    end else if (key_b) begin
                        press   <= 1'b1;
                        presser <= bell_game_pkg::PLAYER_B;
                        state   <= bell_game_pkg::HOLD;
                    end
                end

                // both keys locked out while the referee scores
                bell_game_pkg::HOLD: begin
                    if (round_done) begin
                        state <= bell_game_pkg::RELEASE;
                    end
                end

                bell_game_pkg::RELEASE: begin
                    if (!key_a && !key_b) begin
                        state   <= bell_game_pkg::IDLE;
                        presser <= bell_game_pkg::NOBODY;
                    end
                end

                default: begin
                    state <= bell_game_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* card_pair_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bell_game_macros.svh"

interface card_pair_if;

    logic [`COLOR_W-1:0] color_a;
    logic [`COLOR_W-1:0] color_b;
    logic [`NUM_W-1:0]   num_a;
    logic [`NUM_W-1:0]   num_b;

    // driver side, the top level ports
    modport source (
        output color_a, color_b, num_a, num_b
    );

    modport judge (
        input color_a, color_b, num_a, num_b
    );

endinterface

`default_nettype wire

/* flist.f */
+incdir+.
bell_game_pkg.sv
card_pair_if.sv
buzz_arbiter.sv
round_referee.sv
score_bank.sv
lead_monitor.sv
bell_game_top.sv
bell_game_props.sv
tb_bell_game.sv

/* lead_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bell_game_macros.svh"

module lead_monitor (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`SCORE_W-1:0]  total_a,
    input  logic [`SCORE_W-1:0]  total_b,
    output bell_game_pkg::lead_e lead
);

    localparam logic [`SCORE_W:0] MARGIN = (`SCORE_W+1)'(`LEAD_MARGIN);

    // one extra bit so total plus margin cannot wrap
    logic [`SCORE_W:0] wide_a;
    logic [`SCORE_W:0] wide_b;

    assign wide_a = {1'b0, total_a};
    assign wide_b = {1'b0, total_b};

    always_ff @(posedge clk) begin
        if (!rst) begin
            lead <= bell_game_pkg::LEAD_NONE;
        end else if (wide_a > wide_b + MARGIN) begin
            lead <= bell_game_pkg::LEAD_A;
        end else if (wide_b > wide_a + MARGIN) begin
            lead <= bell_game_pkg::LEAD_B;
        end else begin
            lead <= bell_game_pkg::LEAD_NONE;
        end
    end

endmodule

`default_nettype wire

/* round_referee.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bell_game_macros.svh"

module round_referee (
    input  logic                   clk,
    input  logic                   rst,
    card_pair_if.judge             cards,
    input  logic [`SCORE_W-1:0]    count,
    input  logic                   press,
    input  bell_game_pkg::player_e presser,
    output logic [`SCORE_W-1:0]    delta_a,
    output logic [`SCORE_W-1:0]    delta_b,
    output logic                   round_done
);

    localparam logic [`SCORE_W-1:0] MINUS_ONE = '1;
    localparam logic [`SCORE_W-1:0] PLUS_ONE  = `SCORE_W'(1);

    logic [`NUM_W:0] num_sum; // one bit wider than a card number
    logic            same_color;
    logic            ring_ok;

    assign num_sum    = {1'b0, cards.num_a} + {1'b0, cards.num_b};
    assign same_color = (cards.color_a == cards.color_b);

    always_comb begin
        if (same_color) begin
            ring_ok = (num_sum == (`NUM_W+1)'(`BELL_SUM));
        end else begin
            ring_ok = (cards.num_a == `NUM_W'(`BELL_SUM)) ||
                      (cards.num_b == `NUM_W'(`BELL_SUM));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            delta_a    <= '0;
            delta_b    <= '0;
            round_done <= 1'b0;
        end else begin
            round_done <= press;
            delta_a    <= '0; // zero outside the scoring cycle
            delta_b    <= '0;
            if (press) begin
                case (presser)
                    bell_game_pkg::PLAYER_A: begin
                        delta_a <= ring_ok ? count : MINUS_ONE;
                        delta_b <= ring_ok ? '0 : PLUS_ONE;
                    end
                    bell_game_pkg::PLAYER_B: begin
                        delta_a <= ring_ok ? '0 : PLUS_ONE;
                        delta_b <= ring_ok ? count : MINUS_ONE;
                    end
                    default: begin
                        delta_a <= '0;
                        delta_b <= '0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* score_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bell_game_macros.svh"

module score_bank (
    input  logic                clk,
    input  logic                rst,
    input  logic [`SCORE_W-1:0] delta_a,
    input  logic [`SCORE_W-1:0] delta_b,
    input  logic                round_done,
    output logic [`SCORE_W-1:0] total_a,
    output logic [`SCORE_W-1:0] total_b
);

    // two's complement deltas, so a plain add also subtracts
    always_ff @(posedge clk) begin
        if (!rst) begin
            total_a <= '0;
            total_b <= '0;
        end else if (round_done) begin
            total_a <= total_a + delta_a; // wraps mod 256
            total_b <= total_b + delta_b;
        end
    end

endmodule

`default_nettype wire

/* tb_bell_game.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bell_game_macros.svh"

module tb_bell_game;

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 10;
    localparam int TIMEOUT_CYCLES  = 50;
    localparam int IDLE_CYCLES     = 4;
    localparam int LEAD_TRIES      = 20;
    localparam int RANDOM_ROUNDS   = 24;
    localparam int WATCHDOG_CYCLES = 20000;

    logic                clk;
    logic                rst;
    logic [3:0]          keypad_in;
    logic [`COLOR_W-1:0] color_a;
    logic [`COLOR_W-1:0] color_b;
    logic [`NUM_W-1:0]   num_a;
    logic [`NUM_W-1:0]   num_b;
    logic [`SCORE_W-1:0] count;
    logic [`SCORE_W-1:0] total_a;
    logic [`SCORE_W-1:0] total_b;
    logic                round_done;
    logic [1:0]          lcd_sig;

    integer              seed;
    logic [31:0]         rnd;
    logic [`SCORE_W-1:0] ref_a; // reference totals
    logic [`SCORE_W-1:0] ref_b;
    logic [3:0]          key;
    int                  tries;
    int                  n;

    bell_game_top u_bell_game_top (
        .clk        (clk),
        .rst        (rst),
        .keypad_in  (keypad_in),
        .color_a    (color_a),
        .color_b    (color_b),
        .num_a      (num_a),
        .num_b      (num_b),
        .count      (count),
        .total_a    (total_a),
        .total_b    (total_b),
        .round_done (round_done),
        .lcd_sig    (lcd_sig)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    always @(negedge clk) begin
        if (u_bell_game_top.u_bell_game_props.fail_count != 0) begin
            $display("a concurrent assertion in bell_game_props failed");
            $display("CHECKS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        assert (got === expected) else begin
            $display("ERROR: %s = 0x%02h, expected 0x%02h", name, got, expected);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_round_done(output int cycles);
        cycles = 0;
        while (round_done !== 1'b1) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("no round_done within %0d cycles of a bell press", TIMEOUT_CYCLES);
                $display("CHECKS FAILED");
                $fatal(1, "round_done timeout");
            end
            next_cycle();
            cycles++;
        end
    endtask

    function automatic logic ring_is_correct(input logic [1:0] ca, input logic [1:0] cb,
                                             input logic [2:0] na, input logic [2:0] nb);
        if (ca == cb) begin
            return (int'(na) + int'(nb)) == 5;
        end
        return (int'(na) == 5) || (int'(nb) == 5);
    endfunction

    task automatic score_reference(input logic by_a, input logic correct,
                                   input logic [7:0] cnt);
        if (correct && by_a) begin
            ref_a = ref_a + cnt;
        end else if (correct) begin
            ref_b = ref_b + cnt;
        end else if (by_a) begin
            ref_a = ref_a - 8'd1;
            ref_b = ref_b + 8'd1;
        end else begin
            ref_b = ref_b - 8'd1;
            ref_a = ref_a + 8'd1;
        end
    endtask

    // one round of cards, press, score, release and idle
    task automatic play_round(input logic [3:0] press_key, input logic [3:0] rival_key,
                              input int hold, input logic [1:0] ca, input logic [1:0] cb,
                              input logic [2:0] na, input logic [2:0] nb,
                              input logic [7:0] cnt);
        int latency;
        int pulses;
        int i;
        color_a   = ca;
        color_b   = cb;
        num_a     = na;
        num_b     = nb;
        count     = cnt;
        keypad_in = press_key;
        next_cycle();
        keypad_in = rival_key; // rival rings while the first press is scored
        wait_round_done(latency);
        check_value("round_done_latency", 8'(latency + 1), 8'd2);
        score_reference(press_key == `BELL_KEY_A, ring_is_correct(ca, cb, na, nb), cnt);
        pulses = 1;
        next_cycle();
        check_value("total_a", total_a, ref_a);
        check_value("total_b", total_b, ref_b);
        for (i = 0; i < hold; i++) begin
            if (round_done === 1'b1) pulses++;
            next_cycle();
        end
        keypad_in = 4'h0;
        for (i = 0; i < IDLE_CYCLES; i++) begin
            next_cycle();
            if (round_done === 1'b1) pulses++;
        end
        check_value("round_done_pulses", 8'(pulses), 8'd1);
        check_value("total_a", total_a, ref_a);
        check_value("total_b", total_b, ref_b);
    endtask

    initial begin
        seed      = 56487;
        rst       = 1'b0;
        keypad_in = 4'h0;
        color_a   = '0;
        color_b   = '0;
        num_a     = 3'd1;
        num_b     = 3'd1;
        count     = '0;
        ref_a     = '0;
        ref_b     = '0;

        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b1;
        next_cycle();
        check_value("total_a", total_a, 8'h00);
        check_value("total_b", total_b, 8'h00);
        check_value("lcd_sig", 8'(lcd_sig), 8'h00);

        // correct rings of both kinds, then wrong rings
        play_round(`BELL_KEY_A, `BELL_KEY_A, 3, 2'd1, 2'd1, 3'd2, 3'd3, 8'd12);
        play_round(`BELL_KEY_B, `BELL_KEY_B, 3, 2'd0, 2'd2, 3'd5, 3'd6, 8'd9);
        play_round(`BELL_KEY_A, `BELL_KEY_A, 2, 2'd3, 2'd3, 3'd3, 3'd4, 8'd20);
        play_round(`BELL_KEY_B, `BELL_KEY_B, 2, 2'd1, 2'd2, 3'd1, 3'd2, 8'd20);

        // lockout with a long hold and the rival's key during the round
        play_round(`BELL_KEY_A, `BELL_KEY_B, 25, 2'd2, 2'd0, 3'd4, 3'd5, 8'd3);
        play_round(`BELL_KEY_B, `BELL_KEY_A, 25, 2'd2, 2'd2, 3'd1, 3'd4, 8'd4);

        tries = 0;
        while (lcd_sig !== bell_game_pkg::LEAD_A) begin
            if (tries >= LEAD_TRIES) begin
                $display("lcd_sig never showed player A in the lead");
                $display("CHECKS FAILED");
                $fatal(1, "lead A not reached");
            end
            play_round(`BELL_KEY_A, `BELL_KEY_A, 2, 2'd1, 2'd1, 3'd1, 3'd4, 8'd30);
            tries++;
        end

        tries = 0;
        while (lcd_sig !== bell_game_pkg::LEAD_B) begin
            if (tries >= LEAD_TRIES) begin
                $display("lcd_sig never showed player B in the lead");
                $display("CHECKS FAILED");
                $fatal(1, "lead B not reached");
            end
            play_round(`BELL_KEY_B, `BELL_KEY_B, 2, 2'd0, 2'd3, 3'd5, 3'd2, 8'd40);
            tries++;
        end

        for (n = 0; n < RANDOM_ROUNDS; n++) begin
            rnd = $random(seed);
            key = rnd[31] ? `BELL_KEY_B : `BELL_KEY_A;
            play_round(key, key, int'(rnd[30:28]) + 1, rnd[1:0], rnd[3:2],
                       3'((rnd[11:4] % 8'd7) + 8'd1), 3'((rnd[19:12] % 8'd7) + 8'd1),
                       rnd[27:20]);
        end

        check_value("total_a", total_a, ref_a);
        check_value("total_b", total_b, ref_b);
        if (u_bell_game_top.u_bell_game_props.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire
